//--- Bender.yml
package:
  name: control_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cu_pkg.sv
      - source/cu_opcode_decoder.sv
      - source/cu_sequencer.sv
      - source/cu_output_decoder.sv
      - source/control_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/cu_properties.sv
      - verification/cu_checker.sv
      - verification/control_unit_tb.sv

//--- control_unit.f
+incdir+source
source/cu_pkg.sv
source/cu_opcode_decoder.sv
source/cu_sequencer.sv
source/cu_output_decoder.sv
source/control_unit.sv
verification/cu_properties.sv
verification/cu_checker.sv
verification/control_unit_tb.sv

//--- source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              zflag,
    input  cu_pkg::opcode_e   opcode,
    output cu_pkg::alu_op_e   alu_op,
    output cu_pkg::reg_mask_t read_en,
    output cu_pkg::reg_mask_t write_en,
    output cu_pkg::mem_sel_e  mem_read,
    output logic              mem_write,
    output logic              pc_inc,
    output logic              endop_signal
);
    import cu_pkg::*;

    instr_class_e instr_class;
    alu_op_e      alu_sel;
    reg_idx_e     reg_sel;
    state_e       state;
    alu_op_e      held_alu;
    reg_idx_e     held_reg;
    logic         is_inc;

    cu_opcode_decoder u_opcode_decoder (
        .opcode      (opcode),
        .instr_class (instr_class),
        .alu_sel     (alu_sel),
        .reg_sel     (reg_sel)
    );

    cu_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .zflag        (zflag),
        .instr_class  (instr_class),
        .alu_sel      (alu_sel),
        .reg_sel      (reg_sel),
        .state        (state),
        .held_alu     (held_alu),
        .held_reg     (held_reg),
        .is_inc       (is_inc),
        .endop_signal (endop_signal)
    );

    cu_output_decoder u_output_decoder (
        .state     (state),
        .held_alu  (held_alu),
        .held_reg  (held_reg),
        .is_inc    (is_inc),
        .alu_op    (alu_op),
        .read_en   (read_en),
        .write_en  (write_en),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .pc_inc    (pc_inc)
    );

endmodule

//--- source/cu_defs.svh
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// instruction register width as seen by the control unit
`define CU_OPCODE_WIDTH 12

// datapath registers, one enable bit each
`define CU_REG_COUNT 16

`define CU_STATE_WIDTH 6

// longest stimulus and expect trace, one line per cycle
`define CU_TRACE_MAX 512

`endif

//--- source/cu_opcode_decoder.sv
`timescale 1ns/1ps

module cu_opcode_decoder (
    input  cu_pkg::opcode_e      opcode,
    output cu_pkg::instr_class_e instr_class,
    output cu_pkg::alu_op_e      alu_sel,
    output cu_pkg::reg_idx_e     reg_sel
);
    import cu_pkg::*;

    always_comb
    begin
        instr_class = cls_invalid; // anything outside the table falls back to idle
        alu_sel = alu_idle;
        case (opcode)
            op_clr:      instr_class = cls_clr;
            op_load:     instr_class = cls_load;
            op_jump:     instr_class = cls_jump;
            op_jumpz:    instr_class = cls_jumpz;
            op_store:    instr_class = cls_store;
            op_load_reg: instr_class = cls_load_reg;
            op_endop:    instr_class = cls_endop;
            op_mul, op_add, op_sub, op_inc, op_xor:
                instr_class = cls_alu;
            op_mvac_total, op_mvac_alphap, op_mvac_betap, op_mvac_gammap, op_mvac_r,
            op_mvac_row, op_mvac_cat, op_mvac_cb, op_mvac_rnow, op_mvac_catnow,
            op_mvac_cbnow:
                instr_class = cls_mvac;
            op_mov_total, op_mov_alphap, op_mov_betap, op_mov_gammap, op_mov_r,
            op_mov_row, op_mov_cat, op_mov_cb, op_mov_rnow, op_mov_catnow,
            op_mov_cbnow:
                instr_class = cls_mov;
            default: ;
        endcase
        case (opcode)
            op_mul:  alu_sel = alu_mul;
            op_add:  alu_sel = alu_add;
            op_sub:  alu_sel = alu_sub;
            op_inc:  alu_sel = alu_plus1;
            op_xor:  alu_sel = alu_xor;
            default: alu_sel = alu_idle;
        endcase
    end

    // MVAC and MOV share the register order, so one table serves both
    always_comb
    begin
        case (opcode)
            op_mvac_total,  op_mov_total:  reg_sel = reg_total;
            op_mvac_alphap, op_mov_alphap: reg_sel = reg_alphap;
            op_mvac_betap,  op_mov_betap:  reg_sel = reg_betap;
            op_mvac_gammap, op_mov_gammap: reg_sel = reg_gammap;
            op_mvac_r,      op_mov_r:      reg_sel = reg_r;
            op_mvac_row,    op_mov_row:    reg_sel = reg_row;
            op_mvac_cat,    op_mov_cat:    reg_sel = reg_cat;
            op_mvac_cb,     op_mov_cb:     reg_sel = reg_cb;
            op_mvac_rnow,   op_mov_rnow:   reg_sel = reg_rnow;
            op_mvac_catnow, op_mov_catnow: reg_sel = reg_catnow;
            op_mvac_cbnow,  op_mov_cbnow:  reg_sel = reg_cbnow;
            default:                       reg_sel = reg_ac;
        endcase
    end

endmodule

//--- source/cu_output_decoder.sv
`timescale 1ns/1ps

module cu_output_decoder (
    input  cu_pkg::state_e    state,
    input  cu_pkg::alu_op_e   held_alu,
    input  cu_pkg::reg_idx_e  held_reg,
    input  logic              is_inc,
    output cu_pkg::alu_op_e   alu_op,
    output cu_pkg::reg_mask_t read_en,
    output cu_pkg::reg_mask_t write_en,
    output cu_pkg::mem_sel_e  mem_read,
    output logic              mem_write,
    output logic              pc_inc
);
    import cu_pkg::*;

    function automatic reg_mask_t one_hot(input reg_idx_e idx);
        reg_mask_t mask;
        mask = '0;
        mask[idx] = 1'b1;
        return mask;
    endfunction

    always_comb
    begin
        alu_op    = alu_idle;
        read_en   = '0;
        write_en  = '0;
        mem_read  = mem_none;
        mem_write = 1'b0;
        pc_inc    = 1'b0;
        case (state)
            st_fetch1:
            begin
                write_en = one_hot(reg_ar);
                read_en  = one_hot(reg_pc); // PC onto the bus as the fetch address
            end
            st_fetch2:
            begin
                write_en = one_hot(reg_dr);
                mem_read = mem_instr;
                pc_inc   = 1'b1;
            end
            st_fetch3:
            begin
                write_en = one_hot(reg_ir) | one_hot(reg_ar);
                read_en  = one_hot(reg_dr) | one_hot(reg_pc);
            end
            st_clr:
            begin
                write_en = one_hot(reg_ac);
                alu_op   = alu_zero;
            end
            st_load1, st_jump1:
            begin
                write_en = one_hot(reg_dr); // operand word from instruction memory
                mem_read = mem_instr;
                pc_inc   = (state == st_jump1);
            end
            st_load2:
            begin
                write_en = one_hot(reg_ar);
                read_en  = one_hot(reg_dr);
            end
            st_load3, st_skip1:
                pc_inc = 1'b1;
            st_load4, st_load_reg3:
            begin
                write_en = one_hot(reg_dr);
                mem_read = mem_data; // data memory has priority into DR
            end
            st_load5:
            begin
                write_en = one_hot(reg_ac);
                read_en  = one_hot(reg_dr) | one_hot(reg_pc);
                alu_op   = alu_pass;
            end
            st_alu:
            begin
                write_en = one_hot(reg_ac);
                read_en  = is_inc ? '0 : one_hot(reg_r);
                alu_op   = held_alu;
            end
            st_jump2:
            begin
                write_en = one_hot(reg_pc);
                read_en  = one_hot(reg_dr);
            end
            st_jump3, st_skip2, st_load_reg2:
            begin
                write_en = one_hot(reg_ar);
                read_en  = one_hot(reg_pc);
            end
            st_mvac:
            begin
                write_en = one_hot(held_reg);
                read_en  = one_hot(reg_ac);
            end
            st_mov:
            begin
                write_en = one_hot(reg_ac);
                read_en  = one_hot(held_reg);
                alu_op   = alu_pass;
            end
            st_store1:
            begin
                write_en = one_hot(reg_ar);
                read_en  = one_hot(reg_gammap); // gammap holds the store address
            end
            st_store2:
            begin
                write_en  = one_hot(reg_dr);
                read_en   = one_hot(reg_ac);
                mem_write = 1'b1;
            end
            st_store3:
            begin
                write_en  = one_hot(reg_ar);
                read_en   = one_hot(reg_pc);
                mem_write = 1'b1;
            end
            st_load_reg1:
            begin
                write_en = one_hot(reg_ar);
                read_en  = one_hot(reg_ac);
            end
            st_load_reg4:
            begin
                write_en = one_hot(reg_ac);
                read_en  = one_hot(reg_dr);
                alu_op   = alu_pass;
            end
            default: ; // idle, fetch4 and endop drive nothing
        endcase
    end

endmodule

//--- source/cu_pkg.sv
`include "cu_defs.svh"

package cu_pkg;

    typedef enum logic [`CU_OPCODE_WIDTH-1:0] {
        op_clr          = 0,
        op_load         = 1,
        op_mul          = 2,
        op_add          = 3,
        op_sub          = 4,
        op_inc          = 5,
        op_jump         = 6,
        op_jumpz        = 7,
        op_mvac_total   = 8,
        op_mvac_alphap  = 9,
        op_mvac_betap   = 10,
        op_mvac_gammap  = 11,
        op_mvac_r       = 12,
        op_mvac_row     = 13,
        op_mvac_cat     = 14,
        op_mvac_cb      = 15,
        op_mvac_rnow    = 16,
        op_mvac_catnow  = 17,
        op_mvac_cbnow   = 18,
        op_mov_total    = 19,
        op_mov_alphap   = 20,
        op_mov_betap    = 21,
        op_mov_gammap   = 22,
        op_mov_r        = 23,
        op_mov_row      = 24,
        op_mov_cat      = 25,
        op_mov_cb       = 26,
        op_mov_rnow     = 27,
        op_mov_catnow   = 28,
        op_mov_cbnow    = 29,
        op_store        = 30,
        op_load_reg     = 31,
        op_endop        = 32,
        op_xor          = 33
    } opcode_e;

    // bit position of each register in the read and write masks
    typedef enum logic [3:0] {
        reg_ac, reg_pc, reg_ar, reg_ir, reg_r, reg_row, reg_cat, reg_cb,
        reg_rnow, reg_catnow, reg_cbnow, reg_alphap, reg_betap, reg_gammap,
        reg_total, reg_dr
    } reg_idx_e;

    typedef logic [`CU_REG_COUNT-1:0] reg_mask_t;

    typedef enum logic [3:0] {
        alu_idle, alu_pass, alu_add, alu_sub, alu_mul, alu_plus1, alu_zero, alu_xor
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_data  = 2'd1,
        mem_instr = 2'd2
    } mem_sel_e;

    typedef enum logic [3:0] {
        cls_clr, cls_load, cls_alu, cls_jump, cls_jumpz, cls_mvac, cls_mov,
        cls_store, cls_load_reg, cls_endop, cls_invalid
    } instr_class_e;

    typedef enum logic [`CU_STATE_WIDTH-1:0] {
        st_idle, st_fetch1, st_fetch2, st_fetch3, st_fetch4, st_clr,
        st_load1, st_load2, st_load3, st_load4, st_load5, st_alu,
        st_jump1, st_jump2, st_jump3, st_skip1, st_skip2, st_mvac, st_mov,
        st_store1, st_store2, st_store3,
        st_load_reg1, st_load_reg2, st_load_reg3, st_load_reg4, st_endop
    } state_e;

endpackage

//--- source/cu_sequencer.sv
`timescale 1ns/1ps

module cu_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 zflag,
    input  cu_pkg::instr_class_e instr_class,
    input  cu_pkg::alu_op_e      alu_sel,
    input  cu_pkg::reg_idx_e     reg_sel,
    output cu_pkg::state_e       state,
    output cu_pkg::alu_op_e      held_alu,
    output cu_pkg::reg_idx_e     held_reg,
    output logic                 is_inc,
    output logic                 endop_signal
);
    import cu_pkg::*;

    state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = st_idle;
        case (state)
            st_idle:      next_state = start ? st_fetch1 : st_idle;
            st_fetch1:    next_state = st_fetch2;
            st_fetch2:    next_state = st_fetch3;
            st_fetch3:    next_state = st_fetch4;
            st_fetch4:
            begin
                // the opcode from IR is only looked at here
                case (instr_class)
                    cls_clr:      next_state = st_clr;
                    cls_load:     next_state = st_load1;
                    cls_alu:      next_state = st_alu;
                    cls_jump:     next_state = st_jump1;
                    cls_jumpz:    next_state = zflag ? st_jump1 : st_skip1;
                    cls_mvac:     next_state = st_mvac;
                    cls_mov:      next_state = st_mov;
                    cls_store:    next_state = st_store1;
                    cls_load_reg: next_state = st_load_reg1;
                    cls_endop:    next_state = st_endop;
                    default:      next_state = st_idle;
                endcase
            end
            st_load1:     next_state = st_load2;
            st_load2:     next_state = st_load3;
            st_load3:     next_state = st_load4; // memory latency slot
            st_load4:     next_state = st_load5;
            st_jump1:     next_state = st_jump2;
            st_jump2:     next_state = st_jump3;
            st_skip1:     next_state = st_skip2;
            st_store1:    next_state = st_store2;
            st_store2:    next_state = st_store3;
            st_load_reg1: next_state = st_load_reg2;
            st_load_reg2: next_state = st_load_reg3;
            st_load_reg3: next_state = st_load_reg4;
            st_clr, st_alu, st_mvac, st_mov, st_load5, st_jump3, st_skip2,
            st_store3, st_load_reg4:
                next_state = st_fetch1;
            default:      next_state = st_idle; // endop lands here too
        endcase
    end

    // decoded fields are held for the single execute state that uses them
    always_ff @(posedge clk)
    begin
        if (state == st_fetch4)
        begin
            held_alu <= alu_sel;
            held_reg <= reg_sel;
            is_inc   <= (alu_sel == alu_plus1); // INC has no register operand
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            endop_signal <= 1'b0;
        else if (state == st_endop)
            endop_signal <= 1'b1;
        else if (state == st_idle && start)
            endop_signal <= 1'b0; // cleared as the next program starts
    end

endmodule

//--- verification/control_unit_tb.sv
`timescale 1ns/1ps
`include "cu_defs.svh"

module control_unit_tb;
    import cu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int FIELDS = 10; // words per trace line

    logic      clk;
    logic      reset;
    logic      start;
    logic      zflag;
    opcode_e   opcode;
    alu_op_e   alu_op;
    reg_mask_t read_en;
    reg_mask_t write_en;
    mem_sel_e  mem_read;
    logic      mem_write;
    logic      pc_inc;
    logic      endop_signal;

    logic [15:0] trace_mem [0:`CU_TRACE_MAX*FIELDS-1];
    int          line_count;
    int          line_no;
    logic        trace_loaded;
    logic        check_en;

    logic [3:0]               exp_alu_op;
    logic [`CU_REG_COUNT-1:0] exp_read_en;
    logic [`CU_REG_COUNT-1:0] exp_write_en;
    logic [1:0]               exp_mem_read;
    logic                     exp_mem_write;
    logic                     exp_pc_inc;
    logic                     exp_endop;

    int error_count;
    int check_count;
    int assert_failures;

    control_unit DUT (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .zflag        (zflag),
        .opcode       (opcode),
        .alu_op       (alu_op),
        .read_en      (read_en),
        .write_en     (write_en),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .pc_inc       (pc_inc),
        .endop_signal (endop_signal)
    );

    cu_checker u_checker (
        .clk           (clk),
        .check_en      (check_en),
        .line_no       (line_no),
        .exp_alu_op    (exp_alu_op),
        .exp_read_en   (exp_read_en),
        .exp_write_en  (exp_write_en),
        .exp_mem_read  (exp_mem_read),
        .exp_mem_write (exp_mem_write),
        .exp_pc_inc    (exp_pc_inc),
        .exp_endop     (exp_endop),
        .alu_op        (alu_op),
        .read_en       (read_en),
        .write_en      (write_en),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .pc_inc        (pc_inc),
        .endop_signal  (endop_signal),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    // state is internal to control_unit, so the properties see it through the bind
    bind control_unit cu_properties u_properties (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .read_en      (read_en),
        .write_en     (write_en),
        .mem_write    (mem_write),
        .pc_inc       (pc_inc),
        .endop_signal (endop_signal)
    );

    assign assert_failures = DUT.u_properties.assert_failures;

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int count_lines();
        int n;
        n = 0;
        while (n < `CU_TRACE_MAX && !$isunknown(trace_mem[n*FIELDS]))
            n++;
        return n;
    endfunction

    task automatic apply_line(input int idx);
        int base;
        base          = idx * FIELDS;
        start         = trace_mem[base][0];
        zflag         = trace_mem[base+1][0];
        opcode        = opcode_e'(trace_mem[base+2][`CU_OPCODE_WIDTH-1:0]);
        exp_alu_op    = trace_mem[base+3][3:0];
        exp_read_en   = trace_mem[base+4];
        exp_write_en  = trace_mem[base+5];
        exp_mem_read  = trace_mem[base+6][1:0];
        exp_mem_write = trace_mem[base+7][0];
        exp_pc_inc    = trace_mem[base+8][0];
        exp_endop     = trace_mem[base+9][0];
        line_no       = idx;
        check_en      = 1'b1;
    endtask

    initial
    begin
        clk           = 1'b0;
        reset         = 1'b1;
        start         = 1'b0;
        zflag         = 1'b0;
        opcode        = op_clr;
        check_en      = 1'b0;
        line_no       = 0;
        trace_loaded  = 1'b0;
        exp_alu_op    = '0;
        exp_read_en   = '0;
        exp_write_en  = '0;
        exp_mem_read  = '0;
        exp_mem_write = 1'b0;
        exp_pc_inc    = 1'b0;
        exp_endop     = 1'b0;
        $readmemh("verification/control_unit_trace.txt", trace_mem);
        line_count   = count_lines();
        trace_loaded = 1'b1;
        if (line_count == 0)
            $display("the trace file held no usable lines");

        repeat (2) @(posedge clk);
        for (int i = 0; i < line_count; i++)
        begin
            @(negedge clk);
            reset = 1'b0;
            apply_line(i);
        end
        @(negedge clk);
        check_en = 1'b0;

        $display("summary: %0d compare errors, %0d assertion failures, %0d lines checked",
                 error_count, assert_failures, check_count);
        if (error_count == 0 && assert_failures == 0 && line_count > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // the run is allowed the trace length plus ten spare cycles
    initial
    begin
        wait (trace_loaded === 1'b1);
        #((line_count + 10) * CLK_PERIOD);
        $display("timeout: the trace did not finish within %0d clock cycles", line_count + 10);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verification/control_unit_trace.txt
// start zflag opcode | expected alu_op read_en write_en mem_read mem_write pc_inc endop_signal
// one line per clock cycle, all values in hex
0 0 000 0 0000 0000 0 0 0 0
0 0 000 0 0000 0000 0 0 0 0
1 0 000 0 0000 0000 0 0 0 0
0 0 000 0 0002 0004 0 0 0 0
0 0 000 0 0000 8000 2 0 1 0
0 0 000 0 8002 000c 0 0 0 0
0 0 000 0 0000 0000 0 0 0 0
0 0 000 6 0000 0001 0 0 0 0
0 0 002 0 0002 0004 0 0 0 0
0 0 002 0 0000 8000 2 0 1 0
0 0 002 0 8002 000c 0 0 0 0
0 0 002 0 0000 0000 0 0 0 0
0 0 002 4 0010 0001 0 0 0 0
0 0 003 0 0002 0004 0 0 0 0
0 0 003 0 0000 8000 2 0 1 0
0 0 003 0 8002 000c 0 0 0 0
0 0 003 0 0000 0000 0 0 0 0
0 0 003 2 0010 0001 0 0 0 0
0 0 004 0 0002 0004 0 0 0 0
0 0 004 0 0000 8000 2 0 1 0
0 0 004 0 8002 000c 0 0 0 0
0 0 004 0 0000 0000 0 0 0 0
0 0 004 3 0010 0001 0 0 0 0
0 0 021 0 0002 0004 0 0 0 0
0 0 021 0 0000 8000 2 0 1 0
0 0 021 0 8002 000c 0 0 0 0
0 0 021 0 0000 0000 0 0 0 0
0 0 021 7 0010 0001 0 0 0 0
0 0 005 0 0002 0004 0 0 0 0
0 0 005 0 0000 8000 2 0 1 0
0 0 005 0 8002 000c 0 0 0 0
0 0 005 0 0000 0000 0 0 0 0
0 0 005 5 0000 0001 0 0 0 0
0 0 001 0 0002 0004 0 0 0 0
0 0 001 0 0000 8000 2 0 1 0
0 0 001 0 8002 000c 0 0 0 0
0 0 001 0 0000 0000 0 0 0 0
0 0 001 0 0000 8000 2 0 0 0
0 0 001 0 8000 0004 0 0 0 0
0 0 001 0 0000 0000 0 0 1 0
0 0 001 0 0000 8000 1 0 0 0
0 0 001 1 8002 0001 0 0 0 0
0 0 01e 0 0002 0004 0 0 0 0
0 0 01e 0 0000 8000 2 0 1 0
0 0 01e 0 8002 000c 0 0 0 0
0 0 01e 0 0000 0000 0 0 0 0
0 0 01e 0 2000 0004 0 0 0 0
0 0 01e 0 0001 8000 0 1 0 0
0 0 01e 0 0002 0004 0 1 0 0
0 0 01f 0 0002 0004 0 0 0 0
0 0 01f 0 0000 8000 2 0 1 0
0 0 01f 0 8002 000c 0 0 0 0
0 0 01f 0 0000 0000 0 0 0 0
0 0 01f 0 0001 0004 0 0 0 0
0 0 01f 0 0002 0004 0 0 0 0
0 0 01f 0 0000 8000 1 0 0 0
0 0 01f 1 8000 0001 0 0 0 0
0 0 006 0 0002 0004 0 0 0 0
0 0 006 0 0000 8000 2 0 1 0
0 0 006 0 8002 000c 0 0 0 0
0 0 006 0 0000 0000 0 0 0 0
0 0 006 0 0000 8000 2 0 1 0
0 0 006 0 8000 0002 0 0 0 0
0 0 006 0 0002 0004 0 0 0 0
0 1 007 0 0002 0004 0 0 0 0
0 1 007 0 0000 8000 2 0 1 0
0 1 007 0 8002 000c 0 0 0 0
0 1 007 0 0000 0000 0 0 0 0
0 1 007 0 0000 8000 2 0 1 0
0 1 007 0 8000 0002 0 0 0 0
0 1 007 0 0002 0004 0 0 0 0
0 0 007 0 0002 0004 0 0 0 0
0 0 007 0 0000 8000 2 0 1 0
0 0 007 0 8002 000c 0 0 0 0
0 0 007 0 0000 0000 0 0 0 0
0 0 007 0 0000 0000 0 0 1 0
0 0 007 0 0002 0004 0 0 0 0
0 0 008 0 0002 0004 0 0 0 0
0 0 008 0 0000 8000 2 0 1 0
0 0 008 0 8002 000c 0 0 0 0
0 0 008 0 0000 0000 0 0 0 0
0 0 008 0 0001 4000 0 0 0 0
0 0 012 0 0002 0004 0 0 0 0
0 0 012 0 0000 8000 2 0 1 0
0 0 012 0 8002 000c 0 0 0 0
0 0 012 0 0000 0000 0 0 0 0
0 0 012 0 0001 0400 0 0 0 0
0 0 014 0 0002 0004 0 0 0 0
0 0 014 0 0000 8000 2 0 1 0
0 0 014 0 8002 000c 0 0 0 0
0 0 014 0 0000 0000 0 0 0 0
0 0 014 1 0800 0001 0 0 0 0
0 0 019 0 0002 0004 0 0 0 0
0 0 019 0 0000 8000 2 0 1 0
0 0 019 0 8002 000c 0 0 0 0
0 0 019 0 0000 0000 0 0 0 0
0 0 019 1 0040 0001 0 0 0 0
0 0 020 0 0002 0004 0 0 0 0
0 0 020 0 0000 8000 2 0 1 0
0 0 020 0 8002 000c 0 0 0 0
0 0 020 0 0000 0000 0 0 0 0
0 0 020 0 0000 0000 0 0 0 0
0 0 000 0 0000 0000 0 0 0 1
1 0 000 0 0000 0000 0 0 0 1
0 0 028 0 0002 0004 0 0 0 0
0 0 028 0 0000 8000 2 0 1 0
0 0 028 0 8002 000c 0 0 0 0
0 0 028 0 0000 0000 0 0 0 0
0 0 000 0 0000 0000 0 0 0 0
0 0 000 0 0000 0000 0 0 0 0

//--- verification/cu_checker.sv
`timescale 1ns/1ps
`include "cu_defs.svh"

module cu_checker (
    input  logic                     clk,
    input  logic                     check_en,
    input  int                       line_no,
    input  logic [3:0]               exp_alu_op,
    input  logic [`CU_REG_COUNT-1:0] exp_read_en,
    input  logic [`CU_REG_COUNT-1:0] exp_write_en,
    input  logic [1:0]               exp_mem_read,
    input  logic                     exp_mem_write,
    input  logic                     exp_pc_inc,
    input  logic                     exp_endop,
    input  logic [3:0]               alu_op,
    input  logic [`CU_REG_COUNT-1:0] read_en,
    input  logic [`CU_REG_COUNT-1:0] write_en,
    input  logic [1:0]               mem_read,
    input  logic                     mem_write,
    input  logic                     pc_inc,
    input  logic                     endop_signal,
    output int                       error_count,
    output int                       check_count
);

    task automatic compare_field(input string name,
                                 input logic [`CU_REG_COUNT-1:0] expected,
                                 input logic [`CU_REG_COUNT-1:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error: trace line %0d, %s expected %h, got %h",
                     line_no, name, expected, actual);
        end
    endtask

    initial
    begin
        error_count = 0;
        check_count = 0;
    end

    // outputs are Moore levels, so at the rising edge they still show the cycle just ended
    always @(posedge clk)
    begin
        if (check_en)
        begin
            check_count++;
            compare_field("alu_op", exp_alu_op, alu_op);
            compare_field("read_en", exp_read_en, read_en);
            compare_field("write_en", exp_write_en, write_en);
            compare_field("mem_read", exp_mem_read, mem_read);
            compare_field("mem_write", exp_mem_write, mem_write);
            compare_field("pc_inc", exp_pc_inc, pc_inc);
            compare_field("endop_signal", exp_endop, endop_signal);
        end
    end

endmodule

//--- verification/cu_properties.sv
`timescale 1ns/1ps

module cu_properties (
    input logic              clk,
    input logic              reset,
    input cu_pkg::state_e    state,
    input cu_pkg::reg_mask_t read_en,
    input cu_pkg::reg_mask_t write_en,
    input logic              mem_write,
    input logic              pc_inc,
    input logic              endop_signal
);
    import cu_pkg::*;

    int   assert_failures;
    logic endop_seen;

    initial assert_failures = 0;

    always_ff @(posedge clk)
    begin
        if (reset)
            endop_seen <= 1'b0;
        else if (state == st_endop)
            endop_seen <= 1'b1; // the flag may only rise after this
    end

    no_write_with_pc_inc: assert property (
        @(posedge clk) disable iff (reset) !(mem_write && pc_inc))
    else
    begin
        assert_failures++;
        $error("mem_write and pc_inc are high in the same cycle");
    end

    quiet_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == st_idle) |-> (read_en == '0 && write_en == '0 && !mem_write))
    else
    begin
        assert_failures++;
        $error("a register enable or mem_write is active in idle");
    end

    no_early_endop: assert property (
        @(posedge clk) disable iff (reset) !endop_seen |-> !endop_signal)
    else
    begin
        assert_failures++;
        $error("endop_signal is high before any endop state");
    end

endmodule
